// ==== src/cfg_decoder.sv ====
`include "tile_defs.svh"

module cfg_decoder (
	input  logic                   config_valid,
	input  logic [`TILE_CFG_W-1:0] config_addr,
	input  logic [`TILE_CFG_W-1:0] config_data,
	input  logic [`TILE_ID_W-1:0]  tile_id,
	tile_cfg_if.decoder            cfg
);

	logic [`TILE_TARGET_W-1:0] target;
	logic                      tile_hit;

	assign target   = config_addr[`TILE_CFG_W-1:`TILE_ID_W];
	assign tile_hit = config_valid && (config_addr[`TILE_ID_W-1:0] == tile_id);

	// Target codes are distinct, so at most one enable goes high
	always_comb begin
		cfg.en_sb  = 1'b0;
		cfg.en_cb0 = 1'b0;
		cfg.en_cb1 = 1'b0;
		cfg.en_lb  = 1'b0;
		if (tile_hit) begin
			case (target)
				`TILE_SB_TARGET: cfg.en_sb = 1'b1;
				`TILE_CB0_TARGET: cfg.en_cb0 = 1'b1;
				`TILE_CB1_TARGET: cfg.en_cb1 = 1'b1;
				`TILE_LB_TARGET: cfg.en_lb = 1'b1;
				default: begin
					cfg.en_sb = 1'b0;
				end
			endcase
		end
	end

	// Data passes through, each block reads its own view
	assign cfg.word.raw = config_data;

endmodule

// ==== src/connect_box.sv ====
`include "tile_defs.svh"

module connect_box #(
	parameter int CB_INDEX = 0
) (
	input  logic                       clk,
	input  logic                       rst_n,
	tile_cfg_if.cb                     cfg,
	input  logic [`TILE_CB_TRACKS-1:0] tracks,
	output logic                       operand
);

	logic                      cfg_en;
	logic [`TILE_CB_SEL_W-1:0] track_sel;

	// Obey only the enable that belongs to this instance
	assign cfg_en = (CB_INDEX == 0) ? cfg.en_cb0 : cfg.en_cb1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			track_sel <= '0;
		end else if (cfg_en) begin
			track_sel <= cfg.word.cb.track_sel;
		end
	end

	// Low half from the input side, high half from switch box outputs
	assign operand = tracks[track_sel];

endmodule

// ==== src/logic_block.sv ====
`include "tile_defs.svh"

module logic_block (
	input  logic   clk,
	input  logic   rst_n,
	tile_cfg_if.lb cfg,
	input  logic   op0,
	input  logic   op1,
	output logic   result
);
	import tile_pkg::*;

	lb_func_t func;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			func <= FUNC_AND;
		end else if (cfg.en_lb) begin
			func <= cfg.word.lb.func;
		end
	end

	// Purely combinational from operands to result
	always_comb begin
		case (func)
			FUNC_AND: result = op0 & op1;
			FUNC_OR: result = op0 | op1;
			FUNC_XOR: result = op0 ^ op1;
			FUNC_NAND: result = ~(op0 & op1);
			default: result = 1'b0;
		endcase
	end

endmodule

// ==== src/pe_tile.sv ====
`include "tile_defs.svh"

module pe_tile (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    config_valid,
	input  logic [`TILE_CFG_W-1:0]  config_addr,
	input  logic [`TILE_CFG_W-1:0]  config_data,
	input  logic [`TILE_ID_W-1:0]   tile_id,
	input  logic [`TILE_TRACKS-1:0] in_side0,
	input  logic [`TILE_TRACKS-1:0] in_side1,
	input  logic [`TILE_TRACKS-1:0] in_side2,
	input  logic [`TILE_TRACKS-1:0] in_side3,
	output logic [`TILE_TRACKS-1:0] out_side0,
	output logic [`TILE_TRACKS-1:0] out_side1,
	output logic [`TILE_TRACKS-1:0] out_side2
);

	logic op0;
	logic op1;
	logic pe_result;

	tile_cfg_if cfg_bus ();

	// Address match for all four configurable blocks
	cfg_decoder decoder (
		.config_valid(config_valid),
		.config_addr (config_addr),
		.config_data (config_data),
		.tile_id     (tile_id),
		.cfg         (cfg_bus.decoder)
	);

	switch_box sb (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg      (cfg_bus.sb),
		.in_side0 (in_side0),
		.in_side1 (in_side1),
		.in_side2 (in_side2),
		.in_side3 (in_side3),
		.pe_result(pe_result),
		.out_side0(out_side0),
		.out_side1(out_side1),
		.out_side2(out_side2)
	);

	// Operand A from side 0, tracks 4-7 loop back from the switch box
	connect_box #(
		.CB_INDEX(0)
	) cb0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.cfg    (cfg_bus.cb),
		.tracks ({out_side0, in_side0}),
		.operand(op0)
	);

	// Operand B from side 1
	connect_box #(
		.CB_INDEX(1)
	) cb1 (
		.clk    (clk),
		.rst_n  (rst_n),
		.cfg    (cfg_bus.cb),
		.tracks ({out_side1, in_side1}),
		.operand(op1)
	);

	logic_block lb (
		.clk   (clk),
		.rst_n (rst_n),
		.cfg   (cfg_bus.lb),
		.op0   (op0),
		.op1   (op1),
		.result(pe_result)
	);

endmodule

// ==== src/switch_box.sv ====
`include "tile_defs.svh"

module switch_box (
	input  logic                    clk,
	input  logic                    rst_n,
	tile_cfg_if.sb                  cfg,
	input  logic [`TILE_TRACKS-1:0] in_side0,
	input  logic [`TILE_TRACKS-1:0] in_side1,
	input  logic [`TILE_TRACKS-1:0] in_side2,
	input  logic [`TILE_TRACKS-1:0] in_side3,
	input  logic                    pe_result,
	output logic [`TILE_TRACKS-1:0] out_side0,
	output logic [`TILE_TRACKS-1:0] out_side1,
	output logic [`TILE_TRACKS-1:0] out_side2
);

	// Select value that routes the PE result
	localparam logic [`TILE_SB_SEL_W-1:0] SEL_PE = 2'd3;

	logic [`TILE_SB_OUTS-1:0][`TILE_SB_SEL_W-1:0] sel_q;
	logic [`TILE_SIDES-1:0][`TILE_TRACKS-1:0]     in_sides;
	logic [`TILE_OUT_SIDES-1:0][`TILE_TRACKS-1:0] out_sides;

	// Side 3 has no outgoing tracks in this tile
	assign in_sides = {in_side3, in_side2, in_side1, in_side0};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= '0;
		end else if (cfg.en_sb) begin
			sel_q <= cfg.word.sb.sel;
		end
	end

	// Candidate c is the c-th side other than the output side, ascending
	function automatic int cand_side(input int out_side, input int cand);
		int side;
		if (cand < out_side) begin
			side = cand;
		end else begin
			side = cand + 1;
		end
		return side;
	endfunction

	always_comb begin
		for (int s = 0; s < `TILE_OUT_SIDES; s++) begin
			for (int t = 0; t < `TILE_TRACKS; t++) begin
				if (sel_q[`TILE_TRACKS*s+t] == SEL_PE) begin
					out_sides[s][t] = pe_result;
				end else begin
					out_sides[s][t] = in_sides[cand_side(s, int'(sel_q[`TILE_TRACKS*s+t]))][t];
				end
			end
		end
	end

	assign out_side0 = out_sides[0];
	assign out_side1 = out_sides[1];
	assign out_side2 = out_sides[2];

endmodule

// ==== src/tile_cfg_if.sv ====
interface tile_cfg_if;
	import tile_pkg::*;

	tile_cfg_word_t word;
	logic           en_sb;
	logic           en_cb0;
	logic           en_cb1;
	logic           en_lb;

	modport decoder (
		output word,
		output en_sb,
		output en_cb0,
		output en_cb1,
		output en_lb
	);

	modport sb (input word, input en_sb);

	// Both enables visible, each box picks its own
	modport cb (input word, input en_cb0, input en_cb1);

	modport lb (input word, input en_lb);

endinterface

// ==== src/tile_defs.svh ====
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

// Configuration bus
`define TILE_CFG_W 32
`define TILE_ID_W 16
`define TILE_TARGET_W 16

// Target codes in address bits 31:16
`define TILE_SB_TARGET 16'd7
`define TILE_CB0_TARGET 16'd6
`define TILE_CB1_TARGET 16'd5
`define TILE_LB_TARGET 16'd4

// Routing geometry
`define TILE_SIDES 4
`define TILE_OUT_SIDES 3
`define TILE_TRACKS 4
`define TILE_SB_OUTS (`TILE_OUT_SIDES * `TILE_TRACKS)
`define TILE_CB_TRACKS (2 * `TILE_TRACKS)

// Field widths
`define TILE_SB_SEL_W 2
`define TILE_CB_SEL_W 3
`define TILE_FUNC_W 2

`endif

// ==== src/tile_pkg.sv ====
`include "tile_defs.svh"

package tile_pkg;

	// Two-input function of the logic block
	typedef enum logic [`TILE_FUNC_W-1:0] {
		FUNC_AND  = 2'd0,
		FUNC_OR   = 2'd1,
		FUNC_XOR  = 2'd2,
		FUNC_NAND = 2'd3
	} lb_func_t;

	// One config data word, read differently by each block
	typedef union packed {
		logic [`TILE_CFG_W-1:0] raw;

		// Output (side s, track t) uses sel[4s+t]
		struct packed {
			logic [`TILE_CFG_W-`TILE_SB_OUTS*`TILE_SB_SEL_W-1:0] spare;
			logic [`TILE_SB_OUTS-1:0][`TILE_SB_SEL_W-1:0]        sel;
		} sb;

		// Track index, 0-3 from the input side, 4-7 from the switch box
		struct packed {
			logic [`TILE_CFG_W-`TILE_CB_SEL_W-1:0] spare;
			logic [`TILE_CB_SEL_W-1:0]             track_sel;
		} cb;

		struct packed {
			logic [`TILE_CFG_W-`TILE_FUNC_W-1:0] spare;
			lb_func_t                            func;
		} lb;
	} tile_cfg_word_t;

endpackage

// ==== tb.f ====
+incdir+src
src/tile_pkg.sv
src/tile_cfg_if.sv
src/cfg_decoder.sv
src/connect_box.sv
src/logic_block.sv
src/switch_box.sv
src/pe_tile.sv
tb/tile_clk_gen.sv
tb/pe_tile_tb.sv

// ==== tb/pe_tile_tb.sv ====
`include "tile_defs.svh"

module pe_tile_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int SAMPLE_DELAY = CLK_PERIOD - DRIVE_DELAY - 1;
	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_ROWS  = 200;

	localparam logic [15:0] TILE_ID = 16'h0123;
	localparam logic [31:0] SB_ADDR  = {`TILE_SB_TARGET, TILE_ID};
	localparam logic [31:0] CB0_ADDR = {`TILE_CB0_TARGET, TILE_ID};
	localparam logic [31:0] CB1_ADDR = {`TILE_CB1_TARGET, TILE_ID};
	localparam logic [31:0] LB_ADDR  = {`TILE_LB_TARGET, TILE_ID};

	// Side inputs packed as {in3, in2, in1, in0} and outputs as {out2, out1, out0}
	typedef struct packed {
		logic        is_write;
		logic        valid;
		logic [31:0] addr;
		logic [31:0] data;
		logic [15:0] ins;
		logic [11:0] expected;
	} row_t;

	logic        clk;
	logic        rst_n;
	logic        config_valid;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [15:0] tile_id;
	logic [3:0]  in_side0;
	logic [3:0]  in_side1;
	logic [3:0]  in_side2;
	logic [3:0]  in_side3;
	logic [3:0]  out_side0;
	logic [3:0]  out_side1;
	logic [3:0]  out_side2;

	row_t   rows[$];
	logic   table_built;
	integer seed;

	// Reference state of the tile
	logic [1:0] m_sel [12];
	logic [2:0] m_cb0;
	logic [2:0] m_cb1;
	logic [1:0] m_func;

	tile_clk_gen #(
		.PERIOD_NS(CLK_PERIOD)
	) clk_gen (
		.clk(clk)
	);

	pe_tile uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_valid(config_valid),
		.config_addr (config_addr),
		.config_data (config_data),
		.tile_id     (tile_id),
		.in_side0    (in_side0),
		.in_side1    (in_side1),
		.in_side2    (in_side2),
		.in_side3    (in_side3),
		.out_side0   (out_side0),
		.out_side1   (out_side1),
		.out_side2   (out_side2)
	);

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, actual,
				expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	task automatic check_outputs(input logic [11:0] expected, input string tag);
		check_value({"out_side0", tag}, out_side0, expected[3:0]);
		check_value({"out_side1", tag}, out_side1, expected[7:4]);
		check_value({"out_side2", tag}, out_side2, expected[11:8]);
	endtask

	task automatic add_write_row(input logic valid, input logic [31:0] addr,
			input logic [31:0] data);
		row_t row;
		row = '0;
		row.is_write = 1'b1;
		row.valid = valid;
		row.addr = addr;
		row.data = data;
		rows.push_back(row);
	endtask

	task automatic add_probe_row(input logic [15:0] ins, input logic [11:0] expected);
		row_t row;
		row = '0;
		row.ins = ins;
		row.expected = expected;
		rows.push_back(row);
	endtask

	task automatic build_table();
		// After reset each output takes the lowest other side
		add_probe_row(16'h4321, 12'h112);
		add_probe_row(16'hFA50, 12'h005);
		// Uniform select values 1 and 2
		add_write_row(1'b1, SB_ADDR, 32'h0055_5555);
		add_probe_row(16'h4321, 12'h233);
		add_write_row(1'b1, SB_ADDR, 32'h00AA_AAAA);
		add_probe_row(16'h4321, 12'h444);
		// Mixed selects with one side driven high per probe
		add_write_row(1'b1, SB_ADDR, 32'h0049_9224);
		add_probe_row(16'h000F, 12'h420);
		add_probe_row(16'h00F0, 12'h909);
		add_probe_row(16'h0F00, 12'h042);
		add_probe_row(16'hF000, 12'h294);
		add_write_row(1'b1, SB_ADDR, 32'h0000_0000);
		add_probe_row(16'h4321, 12'h112);
		// Writes that must be ignored
		add_write_row(1'b1, {`TILE_SB_TARGET, TILE_ID + 16'd1}, 32'h00AA_AAAA);
		add_probe_row(16'h4321, 12'h112);
		add_write_row(1'b1, {16'd8, TILE_ID}, 32'h00AA_AAAA);
		add_probe_row(16'h4321, 12'h112);
		add_write_row(1'b0, SB_ADDR, 32'h00AA_AAAA);
		add_probe_row(16'h4321, 12'h112);
		// Side 2 carries the result of operands from input tracks
		add_write_row(1'b1, SB_ADDR, 32'h00FF_0000);
		add_write_row(1'b1, CB0_ADDR, 32'd2);
		add_write_row(1'b1, CB1_ADDR, 32'd1);
		add_probe_row(16'h0024, 12'hF42);
		add_probe_row(16'h0020, 12'h002);
		add_write_row(1'b1, LB_ADDR, 32'd1);
		add_probe_row(16'h0020, 12'hF02);
		add_probe_row(16'h0000, 12'h000);
		add_probe_row(16'h00DB, 12'h0BD);
		add_probe_row(16'h0024, 12'hF42);
		add_write_row(1'b1, LB_ADDR, 32'd2);
		add_probe_row(16'h0024, 12'h042);
		add_probe_row(16'h0004, 12'hF40);
		add_probe_row(16'h0000, 12'h000);
		add_write_row(1'b1, LB_ADDR, 32'd3);
		add_probe_row(16'h0024, 12'h042);
		add_probe_row(16'h0020, 12'hF02);
		add_probe_row(16'h0000, 12'hF00);
		add_write_row(1'b1, CB0_ADDR, 32'd0);
		add_write_row(1'b1, CB1_ADDR, 32'd3);
		add_probe_row(16'h0081, 12'h018);
		add_probe_row(16'h0080, 12'hF08);
		add_write_row(1'b1, CB0_ADDR, 32'd3);
		add_write_row(1'b1, CB1_ADDR, 32'd2);
		add_probe_row(16'h0048, 12'h084);
		add_probe_row(16'h0008, 12'hF80);
		// Operands looped back from switch box outputs
		add_write_row(1'b1, LB_ADDR, 32'd2);
		add_write_row(1'b1, CB0_ADDR, 32'd5);
		add_write_row(1'b1, CB1_ADDR, 32'd6);
		add_probe_row(16'h0024, 12'h042);
		add_probe_row(16'h0020, 12'hF02);
		add_probe_row(16'h0004, 12'hF40);
		add_write_row(1'b1, SB_ADDR, 32'h00FF_AA55);
		add_probe_row(16'h4200, 12'h042);
		add_probe_row(16'h0200, 12'hF02);
		add_probe_row(16'h40FF, 12'hF40);
	endtask

	task automatic model_reset();
		for (int i = 0; i < 12; i++) begin
			m_sel[i] = 2'd0;
		end
		m_cb0 = 3'd0;
		m_cb1 = 3'd0;
		m_func = 2'd0;
	endtask

	task automatic model_write(input logic valid, input logic [31:0] addr,
			input logic [31:0] data);
		if (valid && addr[15:0] == tile_id) begin
			case (addr[31:16])
				`TILE_SB_TARGET: begin
					for (int i = 0; i < 12; i++) begin
						m_sel[i] = data[2*i +: 2];
					end
				end
				`TILE_CB0_TARGET: m_cb0 = data[2:0];
				`TILE_CB1_TARGET: m_cb1 = data[2:0];
				`TILE_LB_TARGET: m_func = data[1:0];
				default: m_func = m_func;
			endcase
		end
	endtask

	// Walk the sides other than s and stop at the selected one
	function automatic logic [11:0] route(input logic [15:0] ins, input logic res);
		logic [11:0] outs;
		int          s;
		int          t;
		int          k;
		int          seen;
		int          side;
		outs = '0;
		for (s = 0; s < 3; s++) begin
			for (t = 0; t < 4; t++) begin
				if (m_sel[4*s+t] == 2'd3) begin
					outs[4*s+t] = res;
				end else begin
					seen = 0;
					side = 0;
					for (k = 0; k < 4; k++) begin
						if (k != s) begin
							if (seen == int'(m_sel[4*s+t])) begin
								side = k;
							end
							seen++;
						end
					end
					outs[4*s+t] = ins[4*side+t];
				end
			end
		end
		return outs;
	endfunction

	function automatic logic [11:0] model_outputs(input logic [15:0] ins);
		logic [11:0] first;
		logic [7:0]  tracks0;
		logic [7:0]  tracks1;
		logic        op0;
		logic        op1;
		logic        res;
		// Routing is loop-free so operand tracks never carry the result
		first = route(ins, 1'b0);
		tracks0 = {first[3:0], ins[3:0]};
		tracks1 = {first[7:4], ins[7:4]};
		op0 = tracks0[m_cb0];
		op1 = tracks1[m_cb1];
		case (m_func)
			2'd0: res = op0 & op1;
			2'd1: res = op0 | op1;
			2'd2: res = op0 ^ op1;
			default: res = ~(op0 & op1);
		endcase
		return route(ins, res);
	endfunction

	task automatic drive_inputs(input logic valid, input logic [31:0] addr,
			input logic [31:0] data, input logic [15:0] ins);
		config_valid = valid;
		config_addr = addr;
		config_data = data;
		in_side0 = ins[3:0];
		in_side1 = ins[7:4];
		in_side2 = ins[11:8];
		in_side3 = ins[15:12];
	endtask

	task automatic run_row(input row_t row);
		@(posedge clk);
		#DRIVE_DELAY;
		if (row.is_write) begin
			drive_inputs(row.valid, row.addr, row.data, row.ins);
		end else begin
			drive_inputs(1'b0, '0, '0, row.ins);
		end
		#SAMPLE_DELAY;
		if (row.is_write) begin
			model_write(row.valid, row.addr, row.data);
		end else begin
			check_outputs(row.expected, "");
			check_outputs(model_outputs(row.ins), " (model)");
		end
	endtask

	task automatic run_random_row();
		int          roll;
		logic        valid;
		logic [15:0] target;
		logic [15:0] id;
		logic [31:0] data;
		logic [15:0] ins;
		roll = $random(seed) & 15;
		valid = (roll != 15);
		id = (roll == 14) ? TILE_ID + 16'd1 : TILE_ID;
		case (roll % 4)
			0: target = `TILE_SB_TARGET;
			1: target = `TILE_CB0_TARGET;
			2: target = `TILE_CB1_TARGET;
			default: target = `TILE_LB_TARGET;
		endcase
		if (roll == 12 || roll == 13) begin
			target = $random(seed);
		end
		data = $random(seed);
		// Keep the result off sides 0 and 1 since they feed the connect boxes
		if (target == `TILE_SB_TARGET) begin
			for (int i = 0; i < 8; i++) begin
				if (data[2*i +: 2] == 2'd3) begin
					data[2*i +: 2] = 2'd0;
				end
			end
		end
		ins = $random(seed);
		@(posedge clk);
		#DRIVE_DELAY;
		drive_inputs(valid, {target, id}, data, ins);
		#SAMPLE_DELAY;
		check_outputs(model_outputs(ins), " (random)");
		model_write(valid, {target, id}, data);
	endtask

	initial begin
		longint limit_ns;
		wait (table_built === 1'b1);
		limit_ns = (rows.size() + RANDOM_ROWS + RESET_CYCLES) * CLK_PERIOD * 2;
		#(limit_ns);
		$display("Timeout: the run did not finish within %0d ns", limit_ns);
		$display("TESTBENCH FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		seed = 32'h4c28_87db;
		table_built = 1'b0;
		rst_n = 1'b0;
		tile_id = TILE_ID;
		drive_inputs(1'b0, '0, '0, '0);
		model_reset();
		build_table();
		table_built = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			run_row(rows[i]);
		end
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			run_random_row();
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== tb/tile_clk_gen.sv ====
module tile_clk_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
	end

	// Free-running, first rising edge at half a period
	always begin
		#(PERIOD_NS / 2);
		clk = ~clk;
	end

endmodule
